// ==== list.f ====
cachePkg.sv
dataCache.sv
loadUnit.sv
storeUnit.sv
memArbiter.sv
mainMemory.sv
memSubsystem.sv
memChecker.sv
memSubsystem_asserts.sv
memSubsystem_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - cachePkg.sv
  - dataCache.sv
  - loadUnit.sv
  - storeUnit.sv
  - memArbiter.sv
  - mainMemory.sv
  - memSubsystem.sv
  - target: test
    files:
      - memChecker.sv
      - memSubsystem_asserts.sv
      - memSubsystem_tb.sv

// ==== memSubsystem_tb.sv ====
module memSubsystem_tb
    import cachePkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              rst;
    logic              loadValid;
    logic [ADDR_W-1:0] loadAddress;
    logic              loadBusy;
    logic              loadDone;
    logic [DATA_W-1:0] loadData;
    logic              storeValid;
    logic [ADDR_W-1:0] storeAddress;
    logic [DATA_W-1:0] storeData;
    logic [MASK_W-1:0] storeMask;
    logic              storeBusy;
    logic              storeDone;

    integer seed       = 13831;
    int     opsIssued  = 0;
    int     cycleCount = 0;
    int     totalErrors;
    int     lw;
    int     sw;
    int     kind;

    memSubsystem memSubsystem_inst (.*);

    memChecker memChecker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ########################################################################
    // stimulus helpers.
    // ########################################################################

    function automatic logic [ADDR_W-1:0] wordAddress(input int word);
        return ADDR_W'(word) << 3;
    endfunction

    // 32-word window, so every set sees eight tags.
    function automatic int randomWord();
        return $unsigned($random(seed)) % 32;
    endfunction

    function automatic int otherWord(input int word);
        return (word + 1 + ($unsigned($random(seed)) % 31)) % 32;
    endfunction

    function automatic logic [DATA_W-1:0] randomData();
        return {$random(seed), $random(seed)};
    endfunction

    // both paths idle first, then one strobe cycle for each chosen path.
    task automatic sendOps(input logic doLoad, input logic doStore, input int loadWord,
                           input int storeWord, input logic [DATA_W-1:0] data,
                           input logic [MASK_W-1:0] mask);
        @(negedge clk);
        while (loadBusy || storeBusy) begin
            @(negedge clk);
        end
        @(posedge clk);
        if (doLoad) begin
            loadValid   <= 1'b1;
            loadAddress <= wordAddress(loadWord);
            opsIssued++;
        end
        if (doStore) begin
            storeValid   <= 1'b1;
            storeAddress <= wordAddress(storeWord);
            storeData    <= data;
            storeMask    <= mask;
            opsIssued++;
        end
        @(posedge clk);
        loadValid  <= 1'b0;
        storeValid <= 1'b0;
    endtask

    task automatic loadWord(input int word);
        sendOps(1'b1, 1'b0, word, 0, '0, '0);
    endtask

    task automatic storeWord(input int word, input logic [DATA_W-1:0] data,
                             input logic [MASK_W-1:0] mask);
        sendOps(1'b0, 1'b1, 0, word, data, mask);
    endtask

    // ########################################################################
    // test sequence.
    // ########################################################################

    initial begin
        rst          = 1'b1;
        loadValid    = 1'b0;
        loadAddress  = '0;
        storeValid   = 1'b0;
        storeAddress = '0;
        storeData    = '0;
        storeMask    = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // cold cache, every load refills.
        for (int i = 0; i < 4; i++) begin
            loadWord(randomWord());
        end

        // whole window written, then each word read twice.
        for (int w = 0; w < 32; w++) begin
            storeWord(w, randomData(), 8'hff);
        end
        for (int w = 0; w < 32; w++) begin
            loadWord(w);
            loadWord(w);
        end

        for (int i = 0; i < 40; i++) begin
            lw = randomWord();
            storeWord(lw, randomData(), MASK_W'($random(seed)));
            loadWord(lw);
        end

        // words 2, 6 and 10 all map to set 2.
        loadWord(2);
        loadWord(6);
        loadWord(10);
        loadWord(6);
        loadWord(2);

        for (int i = 0; i < 20; i++) begin
            lw = randomWord();
            sendOps(1'b1, 1'b1, lw, otherWord(lw), randomData(), MASK_W'($random(seed)));
        end

        for (int i = 0; i < 400; i++) begin
            kind = $unsigned($random(seed)) % 4;
            lw   = randomWord();
            sw   = otherWord(lw);
            sendOps(kind != 2, kind >= 2, lw, sw, randomData(), MASK_W'($random(seed)));
        end

        @(negedge clk);
        while (loadBusy || storeBusy) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);

        totalErrors = memChecker_inst.dataErrors + memChecker_inst.latencyErrors
                    + memChecker_inst.protocolErrors
                    + memSubsystem_inst.memArbiter_inst.arbiterAsserts.failCount
                    + memSubsystem_inst.loadUnit_inst.loadAsserts.failCount;
        $display("loads %0d, stores %0d, data errors %0d, timing errors %0d, %s %0d, %s %0d",
                 memChecker_inst.loadsChecked, memChecker_inst.storesChecked,
                 memChecker_inst.dataErrors, memChecker_inst.latencyErrors,
                 "protocol errors", memChecker_inst.protocolErrors, "assertion failures",
                 memSubsystem_inst.memArbiter_inst.arbiterAsserts.failCount
                 + memSubsystem_inst.loadUnit_inst.loadAsserts.failCount);
        if (totalErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // the limit grows with every operation handed to the DUT.
    initial begin
        while (cycleCount <= 40 * opsIssued + 200) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run stalled after %0d cycles with %0d operations issued",
                 cycleCount, opsIssued);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== memSubsystem_asserts.sv ====
module memSubsystemAsserts (
    input logic clk,
    input logic rst,
    input logic memStart,
    input logic ownerFree,
    input logic memAck,
    input logic storeAck,
    input logic loadAck,
    input logic loadDone
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    // a start strobe always belongs to a granted owner.
    startHasOwner: assert property (@(posedge clk) disable iff (rst) memStart |-> !ownerFree)
        else begin
            failCount++;
            $error("memory start strobe with no owner granted");
        end

    ackOneOwner: assert property (@(posedge clk) disable iff (rst)
                                  memAck |-> (storeAck ^ loadAck))
        else begin
            failCount++;
            $error("memory acknowledge not routed to exactly one owner");
        end

    doneSingleCycle: assert property (@(posedge clk) disable iff (rst) loadDone |=> !loadDone)
        else begin
            failCount++;
            $error("loadDone high in two consecutive cycles");
        end

endmodule

bind memArbiter memSubsystemAsserts arbiterAsserts (
    .clk       (clk),
    .rst       (rst),
    .memStart  (memStart),
    .ownerFree (owner == cachePkg::GRANT_NONE),
    .memAck    (memAck),
    .storeAck  (storeAck),
    .loadAck   (loadAck),
    .loadDone  (1'b0)
);

// an acknowledge reaching the load unit must find it asking for the port.
bind loadUnit memSubsystemAsserts loadAsserts (
    .clk       (clk),
    .rst       (rst),
    .memStart  (1'b0),
    .ownerFree (1'b1),
    .memAck    (memGrantAck),
    .storeAck  (1'b0),
    .loadAck   (memReq && memGrantAck),
    .loadDone  (loadDone)
);

// ==== memChecker.sv ====
module memChecker
    import cachePkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              loadValid,
    input logic [ADDR_W-1:0] loadAddress,
    input logic              loadBusy,
    input logic              loadDone,
    input logic [DATA_W-1:0] loadData,
    input logic              storeValid,
    input logic [ADDR_W-1:0] storeAddress,
    input logic [DATA_W-1:0] storeData,
    input logic [MASK_W-1:0] storeMask,
    input logic              storeBusy,
    input logic              storeDone
);
    timeunit 1ns;
    timeprecision 1ps;

    // reference memory and a tag-only picture of the cache.
    logic [DATA_W-1:0] modelMem [MEM_WORDS];
    logic [TAG_W-1:0]  modelTag [2][SETS];
    logic [1:0]        modelValid [SETS];
    logic [SETS-1:0]   modelRr;

    int dataErrors     = 0;
    int latencyErrors  = 0;
    int protocolErrors = 0;
    int loadsChecked   = 0;
    int storesChecked  = 0;

    logic              loadPending  = 1'b0;
    logic              storePending = 1'b0;
    logic              loadReported;
    logic              storeReported;
    logic              expectHit;
    int                loadAge;
    int                storeAge;
    logic [ADDR_W-1:0] loadAddr;
    logic [ADDR_W-1:0] storeAddr;
    logic [DATA_W-1:0] storeWordData;
    logic [MASK_W-1:0] storeWordMask;
    logic [DATA_W-1:0] expected;
    logic [1:0]        set;
    logic              victim;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            modelMem[i] = 'x;
        end
    end

    function automatic int wordOf(input logic [ADDR_W-1:0] address);
        return int'(address[8:3]);
    endfunction

    function automatic logic [1:0] setOf(input logic [ADDR_W-1:0] address);
        return address[4:3];
    endfunction

    function automatic logic [TAG_W-1:0] tagOf(input logic [ADDR_W-1:0] address);
        return address[ADDR_W-1:5];
    endfunction

    function automatic logic [DATA_W-1:0] mergeBytes(input logic [DATA_W-1:0] oldWord,
                                                     input logic [DATA_W-1:0] newWord,
                                                     input logic [MASK_W-1:0] mask);
        logic [DATA_W-1:0] result;
        result = oldWord;
        for (int b = 0; b < MASK_W; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = newWord[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic predictHit(input logic [ADDR_W-1:0] address);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (modelValid[setOf(address)][w] && modelTag[w][setOf(address)] == tagOf(address)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ########################################################################
    // sampled at the falling edge, where every port is settled.
    // ########################################################################

    always @(negedge clk) begin
        if (rst) begin
            if (loadBusy || storeBusy || loadDone || storeDone) begin
                protocolErrors++;
                $display("[ERROR] in reset loadBusy=%0h storeBusy=%0h loadDone=%0h storeDone=%0h",
                         loadBusy, storeBusy, loadDone, storeDone);
            end
            for (int s = 0; s < SETS; s++) begin
                modelValid[s] = 2'b00;
            end
            modelRr      = '0;
            loadPending  = 1'b0;
            storePending = 1'b0;
        end else begin
            if (loadBusy !== loadPending) begin
                protocolErrors++;
                $display("[ERROR] loadBusy expected %0h got %0h", loadPending, loadBusy);
            end
            if (loadPending) begin
                loadAge++;
            end
            if (loadDone) begin
                if (!loadPending) begin
                    protocolErrors++;
                    $display("loadDone pulsed while no load was outstanding");
                end else begin
                    loadsChecked++;
                    expected = modelMem[wordOf(loadAddr)];
                    if (loadData !== expected) begin
                        dataErrors++;
                        $display("[ERROR] loadData at address %h expected %h got %h",
                                 loadAddr, expected, loadData);
                    end
                    if (expectHit && loadAge != 2) begin
                        latencyErrors++;
                        $display("[ERROR] loadDone hit latency expected 0x2 got 0x%0h", loadAge);
                    end else if (!expectHit && loadAge <= 2) begin
                        latencyErrors++;
                        $display("[ERROR] loadDone miss latency expected above 0x2 got 0x%0h",
                                 loadAge);
                    end
                    loadPending = 1'b0;
                end
            end else if (loadPending && loadAge > 40 && !loadReported) begin
                protocolErrors++;
                loadReported = 1'b1;
                $display("load of address %h got no loadDone within 40 cycles", loadAddr);
            end
            // a miss refills the round-robin victim of its set.
            if (loadValid && !loadBusy) begin
                loadPending  = 1'b1;
                loadReported = 1'b0;
                loadAge      = 0;
                loadAddr     = loadAddress;
                expectHit    = predictHit(loadAddress);
                if (!expectHit) begin
                    set                    = setOf(loadAddress);
                    victim                 = modelRr[set];
                    modelTag[victim][set]  = tagOf(loadAddress);
                    modelValid[set][victim] = 1'b1;
                    modelRr[set]           = ~victim;
                end
            end

            if (storeBusy !== storePending) begin
                protocolErrors++;
                $display("[ERROR] storeBusy expected %0h got %0h", storePending, storeBusy);
            end
            if (storePending) begin
                storeAge++;
            end
            if (storeDone) begin
                if (!storePending) begin
                    protocolErrors++;
                    $display("storeDone pulsed while no store was outstanding");
                end else begin
                    storesChecked++;
                    modelMem[wordOf(storeAddr)] = mergeBytes(modelMem[wordOf(storeAddr)],
                                                             storeWordData, storeWordMask);
                    storePending = 1'b0;
                end
            end else if (storePending && storeAge > 40 && !storeReported) begin
                protocolErrors++;
                storeReported = 1'b1;
                $display("store to address %h got no storeDone within 40 cycles", storeAddr);
            end
            if (storeValid && !storeBusy) begin
                storePending  = 1'b1;
                storeReported = 1'b0;
                storeAge      = 0;
                storeAddr     = storeAddress;
                storeWordData = storeData;
                storeWordMask = storeMask;
            end
        end
    end

endmodule

// ==== memSubsystem.sv ====
module memSubsystem
    import cachePkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              loadValid,
    input  logic [ADDR_W-1:0] loadAddress,
    output logic              loadBusy,
    output logic              loadDone,
    output logic [DATA_W-1:0] loadData,
    input  logic              storeValid,
    input  logic [ADDR_W-1:0] storeAddress,
    input  logic [DATA_W-1:0] storeData,
    input  logic [MASK_W-1:0] storeMask,
    output logic              storeBusy,
    output logic              storeDone
);

    // load side toward cache and arbiter.
    logic [ADDR_W-1:0] cacheAddress;
    logic              cacheHit;
    logic [DATA_W-1:0] cacheData;
    logic              fillValid;
    logic [ADDR_W-1:0] fillAddress;
    logic [DATA_W-1:0] fillData;
    logic              loadReq;
    logic              loadAck;

    // store side.
    logic              storeReq;
    logic              storeAck;
    logic              cacheUpdate;
    logic [ADDR_W-1:0] reqAddress;
    logic [DATA_W-1:0] reqData;
    logic [MASK_W-1:0] reqMask;

    // memory port.
    logic              memStart;
    logic              memWrite;
    logic [ADDR_W-1:0] memAddress;
    logic [DATA_W-1:0] memWriteData;
    logic [MASK_W-1:0] memMask;
    logic              memAck;
    logic [DATA_W-1:0] memReadData;

    dataCache dataCache_inst (
        .clk                (clk),
        .rst                (rst),
        .lookupAddress      (cacheAddress),
        .lookupHit          (cacheHit),
        .lookupData         (cacheData),
        .fillValid          (fillValid),
        .fillAddress        (fillAddress),
        .fillData           (fillData),
        .storeUpdate        (cacheUpdate),
        .storeUpdateAddress (reqAddress),
        .storeUpdateData    (reqData),
        .storeUpdateMask    (reqMask)
    );

    loadUnit loadUnit_inst (
        .clk          (clk),
        .rst          (rst),
        .loadValid    (loadValid),
        .loadAddress  (loadAddress),
        .loadBusy     (loadBusy),
        .loadDone     (loadDone),
        .loadData     (loadData),
        .cacheAddress (cacheAddress),
        .cacheHit     (cacheHit),
        .cacheData    (cacheData),
        .fillValid    (fillValid),
        .fillAddress  (fillAddress),
        .fillData     (fillData),
        .memReq       (loadReq),
        .memGrantAck  (loadAck),
        .memReadData  (memReadData)
    );

    storeUnit storeUnit_inst (
        .clk          (clk),
        .rst          (rst),
        .storeValid   (storeValid),
        .storeAddress (storeAddress),
        .storeData    (storeData),
        .storeMask    (storeMask),
        .storeBusy    (storeBusy),
        .storeDone    (storeDone),
        .memReq       (storeReq),
        .memAck       (storeAck),
        .cacheUpdate  (cacheUpdate),
        .reqAddress   (reqAddress),
        .reqData      (reqData),
        .reqMask      (reqMask)
    );

    // the held load address is also the refill address.
    memArbiter memArbiter_inst (
        .clk          (clk),
        .rst          (rst),
        .storeReq     (storeReq),
        .storeAddress (reqAddress),
        .storeData    (reqData),
        .storeMask    (reqMask),
        .loadReq      (loadReq),
        .loadAddress  (cacheAddress),
        .storeAck     (storeAck),
        .loadAck      (loadAck),
        .memStart     (memStart),
        .memWrite     (memWrite),
        .memAddress   (memAddress),
        .memWriteData (memWriteData),
        .memMask      (memMask),
        .memAck       (memAck)
    );

    mainMemory mainMemory_inst (
        .clk          (clk),
        .memStart     (memStart),
        .memWrite     (memWrite),
        .memAddress   (memAddress),
        .memWriteData (memWriteData),
        .memMask      (memMask),
        .memAck       (memAck),
        .memReadData  (memReadData)
    );

endmodule

// ==== mainMemory.sv ====
module mainMemory
    import cachePkg::*;
(
    input  logic              clk,
    input  logic              memStart,
    input  logic              memWrite,
    input  logic [ADDR_W-1:0] memAddress,
    input  logic [DATA_W-1:0] memWriteData,
    input  logic [MASK_W-1:0] memMask,
    output logic              memAck,
    output logic [DATA_W-1:0] memReadData
);

    logic [DATA_W-1:0]              words [MEM_WORDS];
    logic [MEM_LATENCY-1:0]         startPipe;
    logic [$clog2(MEM_WORDS)-1:0]   wordIndex;

    // word select starts where the byte offset ends, upper bits wrap.
    assign wordIndex = memAddress[INDEX_LO +: $clog2(MEM_WORDS)];

    // the start strobe walks down the pipe and comes out as the acknowledge.
    // it flushes itself while the arbiter is held in reset.
    always_ff @(posedge clk) begin
        startPipe <= {startPipe[MEM_LATENCY-2:0], memStart};
    end

    assign memAck = startPipe[MEM_LATENCY-1];

    // the arbiter keeps the port steady until the acknowledge.
    always_ff @(posedge clk) begin
        if (memAck && memWrite) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (memMask[b]) begin
                    words[wordIndex][8*b +: 8] <= memWriteData[8*b +: 8];
                end
            end
        end
    end

    assign memReadData = words[wordIndex];

endmodule

// ==== memArbiter.sv ====
module memArbiter
    import cachePkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              storeReq,
    input  logic [ADDR_W-1:0] storeAddress,
    input  logic [DATA_W-1:0] storeData,
    input  logic [MASK_W-1:0] storeMask,
    input  logic              loadReq,
    input  logic [ADDR_W-1:0] loadAddress,
    output logic              storeAck,
    output logic              loadAck,
    output logic              memStart,
    output logic              memWrite,
    output logic [ADDR_W-1:0] memAddress,
    output logic [DATA_W-1:0] memWriteData,
    output logic [MASK_W-1:0] memMask,
    input  logic              memAck
);

    grantOwner_e owner;

    // stores win; the choice is only made while the port is free.
    always_ff @(posedge clk) begin
        if (rst) begin
            owner    <= GRANT_NONE;
            memStart <= 1'b0;
        end else begin
            memStart <= 1'b0;
            if (owner == GRANT_NONE) begin
                if (storeReq) begin
                    owner    <= GRANT_STORE;
                    memStart <= 1'b1;
                end else if (loadReq) begin
                    owner    <= GRANT_LOAD;
                    memStart <= 1'b1;
                end
            end else if (memAck) begin
                owner <= GRANT_NONE;
            end
        end
    end

    assign memWrite     = (owner == GRANT_STORE);
    assign memAddress   = memWrite ? storeAddress : loadAddress;
    assign memWriteData = memWrite ? storeData : '0;
    assign memMask      = memWrite ? storeMask : '0;

    assign storeAck = memAck && (owner == GRANT_STORE);
    assign loadAck  = memAck && (owner == GRANT_LOAD);

endmodule

// ==== storeUnit.sv ====
module storeUnit
    import cachePkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              storeValid,
    input  logic [ADDR_W-1:0] storeAddress,
    input  logic [DATA_W-1:0] storeData,
    input  logic [MASK_W-1:0] storeMask,
    output logic              storeBusy,
    output logic              storeDone,
    output logic              memReq,
    input  logic              memAck,
    output logic              cacheUpdate,
    output logic [ADDR_W-1:0] reqAddress,
    output logic [DATA_W-1:0] reqData,
    output logic [MASK_W-1:0] reqMask
);

    storeState_e state;
    logic        accept;

    // a new store waits out the done cycle.
    assign accept = (state == STORE_IDLE) && storeValid && !storeDone;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= STORE_IDLE;
            storeDone <= 1'b0;
        end else begin
            storeDone <= 1'b0;
            case (state)
                STORE_IDLE: begin
                    if (accept) begin
                        state <= STORE_WRITE_WAIT;
                    end
                end
                STORE_WRITE_WAIT: begin
                    if (memAck) begin
                        state     <= STORE_IDLE;
                        storeDone <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reqAddress <= storeAddress;
            reqData    <= storeData;
            reqMask    <= storeMask;
        end
    end

    assign memReq      = (state == STORE_WRITE_WAIT);
    assign cacheUpdate = memReq && memAck;
    assign storeBusy   = memReq || storeDone;

endmodule

// ==== loadUnit.sv ====
module loadUnit
    import cachePkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              loadValid,
    input  logic [ADDR_W-1:0] loadAddress,
    output logic              loadBusy,
    output logic              loadDone,
    output logic [DATA_W-1:0] loadData,
    output logic [ADDR_W-1:0] cacheAddress,
    input  logic              cacheHit,
    input  logic [DATA_W-1:0] cacheData,
    output logic              fillValid,
    output logic [ADDR_W-1:0] fillAddress,
    output logic [DATA_W-1:0] fillData,
    output logic              memReq,
    input  logic              memGrantAck,
    input  logic [DATA_W-1:0] memReadData
);

    loadState_e        state;
    logic [ADDR_W-1:0] addressReg;
    logic [DATA_W-1:0] dataReg;
    logic              accept;

    assign accept = (state == LOAD_IDLE) && loadValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LOAD_IDLE;
        end else begin
            case (state)
                LOAD_IDLE: begin
                    if (loadValid) begin
                        state <= LOAD_LOOKUP;
                    end
                end
                LOAD_LOOKUP: begin
                    state <= cacheHit ? LOAD_DONE : LOAD_REFILL_REQ;
                end
                LOAD_REFILL_REQ, LOAD_REFILL_WAIT: begin
                    state <= memGrantAck ? LOAD_DONE : LOAD_REFILL_WAIT;
                end
                default: begin
                    state <= LOAD_IDLE;
                end
            endcase
        end
    end

    // hit data is taken in LOOKUP, refill data at the acknowledge.
    always_ff @(posedge clk) begin
        if (accept) begin
            addressReg <= loadAddress;
        end
        if (state == LOAD_LOOKUP && cacheHit) begin
            dataReg <= cacheData;
        end else if (fillValid) begin
            dataReg <= memReadData;
        end
    end

    assign memReq    = (state == LOAD_REFILL_REQ) || (state == LOAD_REFILL_WAIT);
    assign fillValid = memReq && memGrantAck;

    assign cacheAddress = addressReg;
    assign fillAddress  = addressReg;
    assign fillData     = memReadData;

    assign loadBusy = (state != LOAD_IDLE);
    assign loadDone = (state == LOAD_DONE);
    assign loadData = dataReg;

endmodule

// ==== dataCache.sv ====
module dataCache
    import cachePkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] lookupAddress,
    output logic              lookupHit,
    output logic [DATA_W-1:0] lookupData,
    input  logic              fillValid,
    input  logic [ADDR_W-1:0] fillAddress,
    input  logic [DATA_W-1:0] fillData,
    input  logic              storeUpdate,
    input  logic [ADDR_W-1:0] storeUpdateAddress,
    input  logic [DATA_W-1:0] storeUpdateData,
    input  logic [MASK_W-1:0] storeUpdateMask
);

    logic [DATA_W-1:0]         wayData [0:1][SETS];
    logic [TAG_W-1:0]          wayTag  [0:1][SETS];
    logic [SETS-1:0][1:0]      wayValid;
    logic [SETS-1:0]           rrBit;

    logic [INDEX_HI-INDEX_LO:0] lookupSet;
    logic [INDEX_HI-INDEX_LO:0] fillSet;
    logic [INDEX_HI-INDEX_LO:0] updateSet;
    logic [1:0]                 lookupWays;
    logic [1:0]                 updateWays;
    logic                       victim;

    assign lookupSet = lookupAddress[INDEX_HI:INDEX_LO];
    assign fillSet   = fillAddress[INDEX_HI:INDEX_LO];
    assign updateSet = storeUpdateAddress[INDEX_HI:INDEX_LO];
    assign victim    = rrBit[fillSet];

    // one bit per way that holds a valid line with a matching tag.
    function automatic logic [1:0] matchWays(input logic [ADDR_W-1:0] address);
        logic [INDEX_HI-INDEX_LO:0] set;
        logic [1:0]                 ways;
        set = address[INDEX_HI:INDEX_LO];
        for (int w = 0; w < 2; w++) begin
            ways[w] = wayValid[set][w] && (wayTag[w][set] == address[ADDR_W-1:INDEX_HI+1]);
        end
        return ways;
    endfunction

    always_comb begin
        lookupWays = matchWays(lookupAddress);
        updateWays = matchWays(storeUpdateAddress);
    end

    assign lookupHit = |lookupWays;

    always_comb begin
        if (lookupWays[0]) begin
            lookupData = wayData[0][lookupSet];
        end else if (lookupWays[1]) begin
            lookupData = wayData[1][lookupSet];
        end else begin
            lookupData = '0;
        end
    end

    // ########################################################################
    // valid bits and round-robin replacement.
    // ########################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            wayValid <= '0;
            rrBit    <= '0;
        end else if (fillValid) begin
            wayValid[fillSet][victim] <= 1'b1;
            rrBit[fillSet]            <= ~victim;
        end
    end

    // ########################################################################
    // tags and line data.
    // ########################################################################

    always_ff @(posedge clk) begin
        if (fillValid) begin
            wayTag[victim][fillSet]  <= fillAddress[ADDR_W-1:INDEX_HI+1];
            wayData[victim][fillSet] <= fillData;
        end
        // only a way that already holds the line takes the store bytes.
        if (storeUpdate) begin
            for (int w = 0; w < 2; w++) begin
                if (updateWays[w]) begin
                    for (int b = 0; b < MASK_W; b++) begin
                        if (storeUpdateMask[b]) begin
                            wayData[w][updateSet][8*b +: 8] <= storeUpdateData[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== cachePkg.sv ====
package cachePkg;

    // ########################################################################
    // sizes of the data path.
    // ########################################################################

    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;
    localparam int MASK_W = 8;

    // two ways per set, one word per line.
    localparam int SETS     = 4;
    localparam int INDEX_LO = 3;
    localparam int INDEX_HI = 4;
    localparam int TAG_W    = ADDR_W - INDEX_HI - 1;

    // backing memory.
    localparam int MEM_WORDS   = 64;
    localparam int MEM_LATENCY = 3;

    // ########################################################################
    // state encodings.
    // ########################################################################

    typedef enum logic [2:0] {
        LOAD_IDLE,
        LOAD_LOOKUP,
        LOAD_REFILL_REQ,
        LOAD_REFILL_WAIT,
        LOAD_DONE
    } loadState_e;

    typedef enum logic [0:0] {
        STORE_IDLE,
        STORE_WRITE_WAIT
    } storeState_e;

    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_STORE,
        GRANT_LOAD
    } grantOwner_e;

endpackage
